/* rtl/pwrSeq_defs.svh */
// Sizing constants for the power sequencer
// The stage delay counts clock cycles, so scale it to the board clock
`ifndef PWRSEQ_DEFS_SVH
`define PWRSEQ_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// State encoding
//////////////////////////////////////////////////////////////////////

// Sixteen states fit in four bits
`define SEQ_STATE_W 4

//////////////////////////////////////////////////////////////////////
// Stage timer
//////////////////////////////////////////////////////////////////////

// Counter width, limits the longest stage delay to 255 cycles
`define SEQ_CNT_W 8
// Minimum dwell in the CPU/memory stage before PCH power-ok
`define SEQ_CPU_MEM_DELAY 20

`endif

/* rtl/pwrSeqPkg.sv */
// Shared types of the power sequencer
// State order matters: the output decode compares state ranges
`include "pwrSeq_defs.svh"

package pwrSeqPkg;

    // Sequencer states, low to high along the power-up path
    typedef enum logic [`SEQ_STATE_W-1:0] {
        Fault, Stby, S3, Off, Ps, ClkSlot, Pch, CpuMem,
        PwrOk, SysPwrOk, CpuPwrGd, Reset, Done, ShutDown, PchOff, PsOff
    } seqState;

    // Stage delay counter value
    typedef logic [`SEQ_CNT_W-1:0] seqCnt;

    // Board level pins seen by the sequencer
    typedef struct packed {
        logic auxPwrgd;
        logic psPwrok;
        logic pchApwrok;
        logic pchCpuPwrgd;
        logic pchPltrstN;
        logic slpS3N;
        logic slpS4N;
        logic ibmcPsonN;
        logic cpuValidcfg;
        logic pchPrsntN;
        logic dbgmodeN;
    } boardIn;

    typedef struct packed {
        logic pch;
        logic mem;
        logic cpu;
    } railGood;

    typedef struct packed {
        logic pch;
        logic mem;
        logic cpu;
    } railFault;

    // Enables and handshakes driven back to the board
    typedef struct packed {
        logic psEn;
        logic cpuClkenN;
        logic pchPwrMain;
        logic memPwrEn;
        logic cpuPwrEn;
        logic pchPwrok;
        logic pchSysPwrok;
        logic cpuPwrgd;
        logic rstBoardN;
    } seqOut;

endpackage

/* rtl/faultMonitor.sv */
// Latches loss of the aux 3.3 V rail and merges the external rail faults
// Rail fault flags pass through combinationally
`timescale 1ns/1ps

module faultMonitor
    import pwrSeqPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     auxPwrgd,
    input  railFault flt,
    input  logic     faultClear,
    output logic     fault
);

    logic auxPwrgdDly;
    logic auxFault;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            auxPwrgdDly <= 1'b0;
        end else begin
            auxPwrgdDly <= auxPwrgd;
        end
    end

    // A falling edge of aux power-good wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            auxFault <= 1'b0;
        end else if (!auxPwrgd && auxPwrgdDly) begin
            auxFault <= 1'b1;
        end else if (faultClear) begin
            auxFault <= 1'b0;
        end
    end

    assign fault = auxFault | flt.pch | flt.mem | flt.cpu;

endmodule

/* rtl/delayTimer.sv */
// Minimum stage time; delayCycles must be at least 2 and fit the counter
// stageDone reads high out of reset and after the count expires
`timescale 1ns/1ps
`include "pwrSeq_defs.svh"

module delayTimer
    import pwrSeqPkg::*;
#(
    parameter int delayCycles = `SEQ_CPU_MEM_DELAY
) (
    input  logic clk,
    input  logic arstN,
    input  logic stageStart,
    output logic stageDone
);

    seqCnt count;

    // Load on the strobe, then count down and hold at zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (stageStart) begin
            count <= seqCnt'(delayCycles - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign stageDone = (count == '0);

endmodule

/* rtl/seqFsm.sv */
// Master power sequencing FSM, one step per clock
// Fault exit needs dbgmodeN low while in Fault
`timescale 1ns/1ps

module seqFsm
    import pwrSeqPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  boardIn  board,
    input  railGood good,
    input  logic    fault,
    input  logic    stageDone,
    output seqState state,
    output logic    faultClear,
    output logic    stageStart
);

    seqState nextState;
    seqState prevState;
    logic    pwrEn;
    logic    s3Req;

    // BMC request with valid CPU config and PCH present, or S3 exit by the PCH
    assign pwrEn = (!board.ibmcPsonN && board.cpuValidcfg && !board.pchPrsntN && !fault)
                   || board.slpS3N;
    assign s3Req = !board.slpS3N && board.slpS4N;

    assign faultClear = (state == Fault) && !board.dbgmodeN;
    assign stageStart = (state == CpuMem) && (prevState != CpuMem);

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= Stby;
            prevState <= Stby;
        end else begin
            state     <= nextState;
            prevState <= state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            Fault:    if (faultClear) nextState = Stby;
            Stby: begin
                if (fault)               nextState = Fault;
                else if (board.auxPwrgd) nextState = Off;
            end
            S3: begin
                if (fault)             nextState = Fault;
                else if (board.slpS3N) nextState = Off;
            end
            Off: begin
                if (fault)      nextState = Fault;
                else if (pwrEn) nextState = Ps;
            end
            // Supply and clock stages back out through PsOff
            Ps: begin
                if (board.psPwrok) nextState = ClkSlot;
                else if (!pwrEn)   nextState = PsOff;
            end
            ClkSlot: begin
                if (board.pchApwrok) nextState = Pch;
                else if (!pwrEn)     nextState = PsOff;
            end
            Pch: begin
                if (good.pch)    nextState = CpuMem;
                else if (!pwrEn) nextState = PchOff;
            end
            // From here on, losing power-enable goes through ShutDown
            // Timer output is still from the last stage in the strobe cycle
            CpuMem: begin
                if (good.mem && stageDone && !stageStart) nextState = PwrOk;
                else if (!pwrEn)                          nextState = ShutDown;
            end
            PwrOk: begin
                if (good.cpu)    nextState = SysPwrOk;
                else if (!pwrEn) nextState = ShutDown;
            end
            SysPwrOk: begin
                if (!pwrEn)                 nextState = ShutDown;
                else if (board.pchCpuPwrgd) nextState = CpuPwrGd;
            end
            CpuPwrGd: begin
                if (board.pchCpuPwrgd) nextState = Reset;
                else if (!pwrEn)       nextState = ShutDown;
            end
            Reset: begin
                if (board.pchPltrstN) nextState = Done;
                else if (!pwrEn)      nextState = ShutDown;
            end
            Done: begin
                if (!pwrEn)                 nextState = ShutDown;
                else if (!board.pchPltrstN) nextState = Reset;
            end
            // Wait for CPU rail off, memory rail off unless entering S3
            ShutDown: begin
                if ((!good.cpu && (!good.mem || s3Req)) || fault) nextState = PchOff;
                else if (!board.slpS3N)                           nextState = PchOff;
            end
            PchOff:   if (!good.pch) nextState = PsOff;
            PsOff: begin
                if (!board.psPwrok) begin
                    if (s3Req)                                   nextState = S3;
                    else if (!board.ibmcPsonN && !board.slpS3N) nextState = PsOff;
                    else                                         nextState = Off;
                end
            end
            default:  nextState = Stby;
        endcase
    end

endmodule

/* rtl/railEnables.sv */
// Registered decode of sequencer state into rail enables and handshakes
// Outputs lag the state by one clock
`timescale 1ns/1ps

module railEnables
    import pwrSeqPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  seqState state,
    input  logic    slpS4N,
    input  logic    pchCpuPwrgd,
    output seqOut   outs
);

    logic cpuMemRange;

    // CPU and memory rails are up from CpuMem until shutdown starts
    assign cpuMemRange = (state >= CpuMem) && (state < ShutDown);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outs <= '0;
        end else begin
            outs.psEn        <= (state >= Ps) && (state < PsOff);
            // Held high while CPU power is sequenced
            outs.cpuClkenN   <= (state >= CpuMem) && (state < PchOff);
            outs.pchPwrMain  <= (state >= Pch) && (state < PchOff);
            outs.cpuPwrEn    <= cpuMemRange;
            outs.pchPwrok    <= (state >= PwrOk) && (state < PchOff);
            outs.pchSysPwrok <= (state >= SysPwrOk) && (state < ShutDown);
            outs.rstBoardN   <= (state == Done);
            outs.cpuPwrgd    <= pchCpuPwrgd;

            // Memory keeps power through S3, drops only once slpS4N goes low
            if (cpuMemRange) begin
                outs.memPwrEn <= 1'b1;
            end else if (!slpS4N) begin
                outs.memPwrEn <= 1'b0;
            end
        end
    end

endmodule

/* rtl/mstrSeq.sv */
// Top level of the master power sequencer
// State is exported for observation only
`timescale 1ns/1ps

module mstrSeq
    import pwrSeqPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  boardIn   board,
    input  railGood  good,
    input  railFault flt,
    output seqOut    outs,
    output seqState  state
);

    logic fault;
    logic faultClear;
    logic stageStart;
    logic stageDone;

    faultMonitor faultMonitor_inst (
        .clk        (clk),
        .arstN      (arstN),
        .auxPwrgd   (board.auxPwrgd),
        .flt        (flt),
        .faultClear (faultClear),
        .fault      (fault)
    );

    delayTimer delayTimer_inst (
        .clk        (clk),
        .arstN      (arstN),
        .stageStart (stageStart),
        .stageDone  (stageDone)
    );

    seqFsm seqFsm_inst (
        .clk        (clk),
        .arstN      (arstN),
        .board      (board),
        .good       (good),
        .fault      (fault),
        .stageDone  (stageDone),
        .state      (state),
        .faultClear (faultClear),
        .stageStart (stageStart)
    );

    railEnables railEnables_inst (
        .clk         (clk),
        .arstN       (arstN),
        .state       (state),
        .slpS4N      (board.slpS4N),
        .pchCpuPwrgd (board.pchCpuPwrgd),
        .outs        (outs)
    );

endmodule

/* sim/mstrSeq_props.sv */
// Ordering rules on the registered sequencer outputs
// Disabled while reset is low
`timescale 1ns/1ps

module mstrSeqProps
    import pwrSeqPkg::*;
(
    input logic  clk,
    input logic  arstN,
    input seqOut outs
);

    int violations = 0;

    // CPU rail only on top of PCH main power
    cpuNeedsPch: assert property (@(posedge clk) disable iff (!arstN)
        outs.cpuPwrEn |-> outs.pchPwrMain)
        else begin
            violations++;
            $error("CPU rail enabled while PCH main power is off");
        end

    // Power-ok rises after the CPU rail, it outlives it through ShutDown
    pwrokAfterCpu: assert property (@(posedge clk) disable iff (!arstN)
        $rose(outs.pchPwrok) |-> outs.cpuPwrEn)
        else begin
            violations++;
            $error("PCH power-ok raised before the CPU rail was enabled");
        end

    resetAfterSysOk: assert property (@(posedge clk) disable iff (!arstN)
        outs.rstBoardN |-> outs.pchSysPwrok)
        else begin
            violations++;
            $error("Board reset released without PCH system power-ok");
        end

endmodule

/* sim/mstrSeqTb.sv */
// Table driven walk through power-up, power-down, faults and S3
// Stage delay is measured on the first power-up, memory good already high
`timescale 1ns/1ps
`include "pwrSeq_defs.svh"

module mstrSeqTb
    import pwrSeqPkg::*;
();

    localparam int StateTimeout = 64;

    // One table row: inputs to drive, state to reach, outputs one cycle later
    typedef struct packed {
        boardIn   board;
        railGood  good;
        railFault flt;
        seqState  state;
        seqOut    outs;
    } stepRow;

    logic     clk = 1'b0;
    logic     arstN;
    boardIn   board;
    railGood  good;
    railFault flt;
    seqOut    outs;
    seqState  state;

    stepRow   steps[$];
    string    stepNames[$];

    int       cycleCount = 0;
    int       cpuEnRise = -1;
    int       pwrokRise = -1;
    logic     cpuEnPrev = 1'b0;
    logic     pwrokPrev = 1'b0;

    always #4 clk = ~clk;

    mstrSeq mstrSeq_inst (
        .clk   (clk),
        .arstN (arstN),
        .board (board),
        .good  (good),
        .flt   (flt),
        .outs  (outs),
        .state (state)
    );

    bind mstrSeq mstrSeqProps mstrSeqProps_inst (
        .clk   (clk),
        .arstN (arstN),
        .outs  (outs)
    );

    // Stage delay at the outputs, first power-up only
    always @(negedge clk) begin
        cycleCount++;
        if (outs.cpuPwrEn && !cpuEnPrev && cpuEnRise < 0) cpuEnRise = cycleCount;
        if (outs.pchPwrok && !pwrokPrev && pwrokRise < 0) pwrokRise = cycleCount;
        cpuEnPrev = outs.cpuPwrEn;
        pwrokPrev = outs.pchPwrok;
    end

    // Stop on the first failed sequencing assertion
    always @(negedge clk) begin
        if (mstrSeq_inst.mstrSeqProps_inst.violations != 0) begin
            $display("A sequencing assertion failed during the run");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Assertion failure");
        end
    end

    task automatic addStep(input string name, input boardIn b, input railGood g,
                           input railFault f, input seqState s, input seqOut o);
        stepRow row;
        row.board = b;
        row.good  = g;
        row.flt   = f;
        row.state = s;
        row.outs  = o;
        steps.push_back(row);
        stepNames.push_back(name);
    endtask

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic waitForState(input string stepName, input seqState expected);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (state != expected && cycles < StateTimeout) begin
            cycles++;
            @(negedge clk);
        end
        if (state != expected) begin
            $display("Timeout in %s: state %s was never reached, the machine sits in %s",
                     stepName, expected.name(), state.name());
            $display("TEST RESULT: FAIL");
            $fatal(1, "State wait timed out");
        end
    endtask

    initial begin
        // Board columns: aux ps pchA cpuPg pltrst _ s3N s4N _ psonN validcfg prsntN dbgN
        // Outs columns: psEn clkenN pchMain memEn cpuEn pchPwrok sysPwrok cpuPwrgd rstN
        addStep("reset_stby",   11'b00000_00_1101, 3'b000, 3'b000, Stby,     9'b000000000);
        addStep("aux_on",       11'b10000_00_1101, 3'b000, 3'b000, Off,      9'b000000000);
        addStep("bmc_on",       11'b10000_00_0101, 3'b000, 3'b000, Ps,       9'b100000000);
        addStep("ps_ok",        11'b11000_00_0101, 3'b000, 3'b000, ClkSlot,  9'b100000000);
        addStep("pch_apwrok",   11'b11100_00_0101, 3'b000, 3'b000, Pch,      9'b101000000);
        addStep("pch_mem_good", 11'b11100_00_0101, 3'b110, 3'b000, CpuMem,   9'b111110000);
        addStep("stage_done",   11'b11100_00_0101, 3'b110, 3'b000, PwrOk,    9'b111111000);
        addStep("cpu_good",     11'b11100_00_0101, 3'b111, 3'b000, SysPwrOk, 9'b111111100);
        addStep("cpu_pwrgd",    11'b11110_00_0101, 3'b111, 3'b000, CpuPwrGd, 9'b111111110);
        addStep("plt_reset",    11'b11110_00_0101, 3'b111, 3'b000, Reset,    9'b111111110);
        addStep("plt_release",  11'b11111_00_0101, 3'b111, 3'b000, Done,     9'b111111111);
        // Power-down to Off
        addStep("bmc_off",      11'b11111_00_1101, 3'b111, 3'b000, ShutDown, 9'b111001010);
        addStep("cpu_mem_off",  11'b11100_00_1101, 3'b100, 3'b000, PchOff,   9'b100000000);
        addStep("pch_off",      11'b11100_00_1101, 3'b000, 3'b000, PsOff,    9'b000000000);
        addStep("ps_off",       11'b10000_00_1101, 3'b000, 3'b000, Off,      9'b000000000);
        // Aux loss latches until dbgmodeN goes low
        addStep("aux_loss",     11'b00000_00_1101, 3'b000, 3'b000, Fault,    9'b000000000);
        addStep("aux_back",     11'b10000_00_1101, 3'b000, 3'b000, Fault,    9'b000000000);
        addStep("dbg_clear",    11'b10000_00_1100, 3'b000, 3'b000, Stby,     9'b000000000);
        addStep("dbg_release",  11'b10000_00_1101, 3'b000, 3'b000, Off,      9'b000000000);
        addStep("rail_fault",   11'b10000_00_1101, 3'b000, 3'b010, Fault,    9'b000000000);
        addStep("rail_clear",   11'b10000_00_1100, 3'b000, 3'b000, Stby,     9'b000000000);
        // Full power-up in one step, then down into S3
        addStep("repower",      11'b11111_11_0101, 3'b111, 3'b000, Done,     9'b111111111);
        addStep("s3_entry",     11'b10000_01_1101, 3'b010, 3'b000, S3,       9'b000100000);
        addStep("s4_entry",     11'b10000_00_1101, 3'b010, 3'b000, S3,       9'b000000000);

        arstN = 1'b0;
        board = steps[0].board;
        good  = steps[0].good;
        flt   = steps[0].flt;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            board <= steps[i].board;
            good  <= steps[i].good;
            flt   <= steps[i].flt;
            waitForState(stepNames[i], steps[i].state);
            @(posedge clk);
            @(negedge clk);
            compareValue(stepNames[i], steps[i].outs, outs);
        end

        // CpuMem lasts the strobe cycle plus the full stage delay
        compareValue("stage_delay", `SEQ_CPU_MEM_DELAY + 1, pwrokRise - cpuEnRise);

        if (mstrSeq_inst.mstrSeqProps_inst.violations == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Sequencing assertions failed %0d times",
                     mstrSeq_inst.mstrSeqProps_inst.violations);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Assertion failures during the run");
        end
    end

endmodule

/* all.f */
+incdir+rtl
rtl/pwrSeqPkg.sv
rtl/faultMonitor.sv
rtl/delayTimer.sv
rtl/seqFsm.sv
rtl/railEnables.sv
rtl/mstrSeq.sv
sim/mstrSeq_props.sv
sim/mstrSeqTb.sv

/* Bender.yml */
package:
  name: mstrSeq

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pwrSeqPkg.sv
      - rtl/faultMonitor.sv
      - rtl/delayTimer.sv
      - rtl/seqFsm.sv
      - rtl/railEnables.sv
      - rtl/mstrSeq.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/mstrSeq_props.sv
      - sim/mstrSeqTb.sv
